// ==== common/mem_stage_pkg.sv ====
////////////////////////////////////////
// memory stage shared definitions
// data types, microstates, control word layout
// and data cache geometry
////////////////////////////////////////

package mem_stage_pkg;

    localparam int ADDR_W  = 32;
    localparam int DWORD_W = 64;
    localparam int SIZE_W  = 3;
    localparam int UADDR_W = 3;
    localparam int COND_W  = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DWORD_W-1:0] dword_t;
    typedef logic [SIZE_W-1:0]  size_t;
    typedef logic [UADDR_W-1:0] uaddr_t;
    typedef logic [COND_W-1:0]  cond_t;

    // access size codes, anything above SZ_8 reads as 8 bytes
    localparam size_t SZ_1 = 3'd0;
    localparam size_t SZ_2 = 3'd1;
    localparam size_t SZ_4 = 3'd2;
    localparam size_t SZ_8 = 3'd3;

    typedef enum uaddr_t {
        U_IDLE  = 3'd0,
        U_REQ0  = 3'd1,
        U_WAIT0 = 3'd2,
        U_REQ1  = 3'd3,
        U_WAIT1 = 3'd4,
        U_DONE  = 3'd5
    } ustate_t;

    // branch conditions tested by the microsequencer
    localparam cond_t COND_NONE      = 2'd0;
    localparam cond_t COND_START     = 2'd1;
    localparam cond_t COND_REQ_READY = 2'd2;
    localparam cond_t COND_DP_VALID  = 2'd3;

    // control word: jump | cond | alt | req | dp_ready | ld0 | ld1 | done
    localparam int UWORD_W         = 13;
    localparam int UW_JUMP_LSB     = 10;
    localparam int UW_COND_LSB     = 8;
    localparam int UW_ALT_LSB      = 5;
    localparam int UW_RD_REQ_VALID = 4;
    localparam int UW_RD_DP_READY  = 3;
    localparam int UW_LD_OP0       = 2;
    localparam int UW_LD_OP1       = 1;
    localparam int UW_DONE         = 0;

    typedef logic [UWORD_W-1:0] uword_t;

    // one doubleword per line, index from address bits 6:3
    localparam int DC_LINES     = 16;
    localparam int DC_INDEX_W   = 4;
    localparam int DC_TAG_W     = 25;
    localparam int DC_LAT_W     = 3;
    localparam int HIT_LATENCY  = 1;
    localparam int MISS_LATENCY = 6;
    localparam logic [31:0] BACKING_KEY = 32'h5a5a5a5a;

    typedef logic [DC_INDEX_W-1:0] index_t;
    typedef logic [DC_TAG_W-1:0]   tag_t;
    typedef logic [DC_LAT_W-1:0]   lat_t;

endpackage

// ==== dcache_interface/dcache_ctrl_store.sv ====
////////////////////////////////////////
// dcache interface control store
// microstate to control word table
////////////////////////////////////////

`timescale 1ns/100ps

module dcache_ctrl_store (
    input  mem_stage_pkg::uaddr_t uaddr,
    output mem_stage_pkg::uword_t uword
);
    import mem_stage_pkg::*;

    function automatic uword_t make_word(
        input uaddr_t jump,
        input cond_t  cond,
        input uaddr_t alt,
        input logic   req,
        input logic   dp_ready,
        input logic   ld0,
        input logic   ld1,
        input logic   done
    );
        uword_t w;
        w = '0;
        w[UW_JUMP_LSB +: UADDR_W] = jump;
        w[UW_COND_LSB +: COND_W]  = cond;
        w[UW_ALT_LSB +: UADDR_W]  = alt;
        w[UW_RD_REQ_VALID]        = req;
        w[UW_RD_DP_READY]         = dp_ready;
        w[UW_LD_OP0]              = ld0;
        w[UW_LD_OP1]              = ld1;
        w[UW_DONE]                = done;
        return w;
    endfunction

    // rom contents, alt is taken when cond holds
    always_comb begin
        case (uaddr)
            U_IDLE:  uword = make_word(U_IDLE, COND_START, U_REQ0,
                                       1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            U_REQ0:  uword = make_word(U_REQ0, COND_REQ_READY, U_WAIT0,
                                       1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
            U_WAIT0: uword = make_word(U_WAIT0, COND_DP_VALID, U_DONE,
                                       1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
            U_REQ1:  uword = make_word(U_REQ1, COND_REQ_READY, U_WAIT1,
                                       1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
            U_WAIT1: uword = make_word(U_WAIT1, COND_DP_VALID, U_DONE,
                                       1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
            U_DONE:  uword = make_word(U_IDLE, COND_NONE, U_IDLE,
                                       1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
            // unused microaddresses fall back to idle
            default: uword = make_word(U_IDLE, COND_NONE, U_IDLE,
                                       1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        endcase
    end

endmodule

// ==== dcache_interface/dcache_microsequencer.sv ====
////////////////////////////////////////
// dcache interface microsequencer
// microaddress register and branch select
////////////////////////////////////////

`timescale 1ns/100ps

module dcache_microsequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_stage_pkg::uaddr_t jump,
    input  mem_stage_pkg::uaddr_t alt,
    input  mem_stage_pkg::cond_t  cond,
    input  logic                  start,
    input  logic                  rd_req_ready,
    input  logic                  rd_dp_valid,
    input  logic                  op1_valid,
    output mem_stage_pkg::uaddr_t uaddr
);
    import mem_stage_pkg::*;

    logic   cond_true;
    uaddr_t next_uaddr;

    always_comb begin
        case (cond)
            COND_NONE:      cond_true = 1'b0;
            COND_START:     cond_true = start;
            COND_REQ_READY: cond_true = rd_req_ready;
            COND_DP_VALID:  cond_true = rd_dp_valid;
            default:        cond_true = 1'b0;
        endcase
    end

    always_comb begin
        next_uaddr = cond_true ? alt : jump;
        // op0 captured, go fetch op1 if the requester asked for it
        if (uaddr == U_WAIT0 && cond_true && op1_valid) begin
            next_uaddr = U_REQ1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uaddr <= U_IDLE;
        end else begin
            uaddr <= next_uaddr;
        end
    end

endmodule

// ==== dcache_interface/dcache_interface.sv ====
////////////////////////////////////////
// dcache interface top
// start detect, address select, alignment
// and the op0/op1 data registers
////////////////////////////////////////

`timescale 1ns/100ps

module dcache_interface (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a_valid,
    input  logic                  op0_valid,
    input  logic                  op1_valid,
    input  mem_stage_pkg::addr_t  op0_address,
    input  mem_stage_pkg::addr_t  op1_address,
    input  mem_stage_pkg::size_t  size,
    output mem_stage_pkg::dword_t op0_data,
    output mem_stage_pkg::dword_t op1_data,
    output logic                  a_ready,
    output logic                  e_valid,
    output logic                  rd_req_valid,
    input  logic                  rd_req_ready,
    output mem_stage_pkg::addr_t  rd_req_address,
    input  logic                  rd_dp_valid,
    output logic                  rd_dp_ready,
    input  mem_stage_pkg::dword_t rd_dp_read_data
);
    import mem_stage_pkg::*;

    uaddr_t uaddr;
    uword_t uword;
    uaddr_t jump;
    uaddr_t alt_field;
    uaddr_t alt;
    cond_t  cond;
    logic   ld_op0;
    logic   ld_op1;
    logic   done;
    logic   start;
    logic   op1_phase;
    addr_t  cur_addr;
    dword_t shifted;
    dword_t aligned;

    dcache_ctrl_store ctrl_store_inst (
        .uaddr (uaddr),
        .uword (uword)
    );

    // control word fields
    assign jump         = uword[UW_JUMP_LSB +: UADDR_W];
    assign cond         = uword[UW_COND_LSB +: COND_W];
    assign alt_field    = uword[UW_ALT_LSB +: UADDR_W];
    assign rd_req_valid = uword[UW_RD_REQ_VALID];
    assign rd_dp_ready  = uword[UW_RD_DP_READY];
    assign ld_op0       = uword[UW_LD_OP0];
    assign ld_op1       = uword[UW_LD_OP1];
    assign done         = uword[UW_DONE];
    assign a_ready      = done;
    assign e_valid      = done;

    assign start = a_valid && (op0_valid || op1_valid);

    // start branch skips op0 when only op1 is requested
    assign alt = (uaddr == U_IDLE && !op0_valid) ? U_REQ1 : alt_field;

    dcache_microsequencer useq_inst (
        .clk          (clk),
        .rst          (rst),
        .jump         (jump),
        .alt          (alt),
        .cond         (cond),
        .start        (start),
        .rd_req_ready (rd_req_ready),
        .rd_dp_valid  (rd_dp_valid),
        .op1_valid    (op1_valid),
        .uaddr        (uaddr)
    );

    // address mux by microstate
    assign op1_phase      = (uaddr == U_REQ1) || (uaddr == U_WAIT1);
    assign cur_addr       = op1_phase ? op1_address : op0_address;
    assign rd_req_address = cur_addr;

    // byte offset shift then zero extend to the access size
    assign shifted = rd_dp_read_data >> {cur_addr[2:0], 3'b000};

    always_comb begin
        case (size)
            SZ_1:    aligned = {56'h0, shifted[7:0]};
            SZ_2:    aligned = {48'h0, shifted[15:0]};
            SZ_4:    aligned = {32'h0, shifted[31:0]};
            SZ_8:    aligned = shifted;
            default: aligned = shifted;
        endcase
    end

    // mdr pair, load only on a response transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            op0_data <= '0;
            op1_data <= '0;
        end else begin
            if (ld_op0 && rd_dp_valid) begin
                op0_data <= aligned;
            end
            if (ld_op1 && rd_dp_valid) begin
                op1_data <= aligned;
            end
        end
    end

endmodule

// ==== dcache/dcache.sv ====
////////////////////////////////////////
// read-only direct-mapped data cache
// tag compare, latency counter, backing store
////////////////////////////////////////

`timescale 1ns/100ps

module dcache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_req_valid,
    output logic                  rd_req_ready,
    input  mem_stage_pkg::addr_t  rd_req_address,
    output logic                  rd_dp_valid,
    input  logic                  rd_dp_ready,
    output mem_stage_pkg::dword_t rd_dp_read_data
);
    import mem_stage_pkg::*;

    logic [DC_LINES-1:0] line_valid;
    tag_t                tag_mem  [DC_LINES];
    dword_t              data_mem [DC_LINES];

    logic   busy;
    lat_t   lat_cnt;
    dword_t resp_data;
    index_t req_index;
    tag_t   req_tag;
    logic   req_hit;
    logic   req_fire;
    logic   resp_fire;
    dword_t fill_data;

    // backing memory: upper half is the doubleword number xor key
    function automatic dword_t backing_word(input addr_t addr);
        logic [31:0] w;
        w = {3'b000, addr[31:3]};
        return {w ^ BACKING_KEY, w};
    endfunction

    assign req_index = rd_req_address[DC_INDEX_W+2:3];
    assign req_tag   = rd_req_address[ADDR_W-1:ADDR_W-DC_TAG_W];
    assign req_hit   = line_valid[req_index] && (tag_mem[req_index] == req_tag);
    assign fill_data = backing_word(rd_req_address);

    assign rd_req_ready    = !busy;
    assign req_fire        = rd_req_valid && rd_req_ready;
    assign rd_dp_valid     = busy && (lat_cnt == '0);
    assign resp_fire       = rd_dp_valid && rd_dp_ready;
    assign rd_dp_read_data = resp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            lat_cnt    <= '0;
            line_valid <= '0;
        end else begin
            if (req_fire) begin
                busy    <= 1'b1;
                lat_cnt <= req_hit ? lat_t'(HIT_LATENCY) : lat_t'(MISS_LATENCY);
                if (!req_hit) begin
                    line_valid[req_index] <= 1'b1;
                end
            end else if (busy) begin
                if (lat_cnt != '0) begin
                    lat_cnt <= lat_cnt - 1'b1;
                end else if (resp_fire) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // line fill and response capture at acceptance
    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp_data <= req_hit ? data_mem[req_index] : fill_data;
            if (!req_hit) begin
                tag_mem[req_index]  <= req_tag;
                data_mem[req_index] <= fill_data;
            end
        end
    end

endmodule

// ==== source/mem_stage_top.sv ====
////////////////////////////////////////
// memory stage operand load top
// dcache interface wired to the data cache
////////////////////////////////////////

`timescale 1ns/100ps

module mem_stage_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  a_valid,
    input  logic                  op0_valid,
    input  logic                  op1_valid,
    input  mem_stage_pkg::addr_t  op0_address,
    input  mem_stage_pkg::addr_t  op1_address,
    input  mem_stage_pkg::size_t  size,
    output mem_stage_pkg::dword_t op0_data,
    output mem_stage_pkg::dword_t op1_data,
    output logic                  a_ready,
    output logic                  e_valid
);
    import mem_stage_pkg::*;

    logic   rd_req_valid;
    logic   rd_req_ready;
    addr_t  rd_req_address;
    logic   rd_dp_valid;
    logic   rd_dp_ready;
    dword_t rd_dp_read_data;

    dcache_interface dcache_interface_inst (
        .clk             (clk),
        .rst             (rst),
        .a_valid         (a_valid),
        .op0_valid       (op0_valid),
        .op1_valid       (op1_valid),
        .op0_address     (op0_address),
        .op1_address     (op1_address),
        .size            (size),
        .op0_data        (op0_data),
        .op1_data        (op1_data),
        .a_ready         (a_ready),
        .e_valid         (e_valid),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_req_address  (rd_req_address),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_read_data (rd_dp_read_data)
    );

    dcache dcache_inst (
        .clk             (clk),
        .rst             (rst),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_req_address  (rd_req_address),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_read_data (rd_dp_read_data)
    );

endmodule

// ==== verif/tb_mem_stage.sv ====
////////////////////////////////////////
// memory stage testbench
// directed and random load table, data and
// latency checks against the backing store
////////////////////////////////////////

`timescale 1ns/100ps

module tb_mem_stage;
    import mem_stage_pkg::*;

    logic   clk;
    logic   rst;
    logic   a_valid;
    logic   op0_valid;
    logic   op1_valid;
    addr_t  op0_address;
    addr_t  op1_address;
    size_t  size;
    dword_t op0_data;
    dword_t op1_data;
    logic   a_ready;
    logic   e_valid;

    // stimulus table, a cycle count of 0 leaves latency unchecked
    string  row_name   [$];
    addr_t  row_addr0  [$];
    logic   row_valid0 [$];
    addr_t  row_addr1  [$];
    logic   row_valid1 [$];
    size_t  row_size   [$];
    int     row_cycles [$];

    // expected contents of the two data registers
    dword_t exp_op0;
    dword_t exp_op1;
    integer seed;
    int     timeout_cycles = 50;
    int     idle_window = 20;

    mem_stage_top mem_stage_top_inst (
        .clk         (clk),
        .rst         (rst),
        .a_valid     (a_valid),
        .op0_valid   (op0_valid),
        .op1_valid   (op1_valid),
        .op0_address (op0_address),
        .op1_address (op1_address),
        .size        (size),
        .op0_data    (op0_data),
        .op1_data    (op1_data),
        .a_ready     (a_ready),
        .e_valid     (e_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input dword_t expected, input dword_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(input string name, input addr_t a0, input logic v0,
                           input addr_t a1, input logic v1, input size_t sz,
                           input int cycles);
        row_name.push_back(name);
        row_addr0.push_back(a0);
        row_valid0.push_back(v0);
        row_addr1.push_back(a1);
        row_valid1.push_back(v1);
        row_size.push_back(sz);
        row_cycles.push_back(cycles);
    endtask

    // backing word picked apart byte by byte from the offset
    function automatic dword_t expected_load(input addr_t addr, input size_t sz);
        logic [31:0] dw_num;
        dword_t      stored;
        dword_t      result;
        int          nbytes;
        int          off;
        int          i;
        dw_num = {3'b000, addr[31:3]};
        stored = {dw_num ^ BACKING_KEY, dw_num};
        case (sz)
            SZ_1:    nbytes = 1;
            SZ_2:    nbytes = 2;
            SZ_4:    nbytes = 4;
            default: nbytes = 8;
        endcase
        off = int'(addr[2:0]);
        result = '0;
        for (i = 0; i < nbytes; i++) begin
            result[8*i +: 8] = stored[8*(off+i) +: 8];
        end
        return result;
    endfunction

    function automatic addr_t align_to_size(input addr_t addr, input size_t sz);
        case (sz)
            SZ_1:    return addr;
            SZ_2:    return {addr[31:1], 1'b0};
            SZ_4:    return {addr[31:2], 2'b00};
            default: return {addr[31:3], 3'b000};
        endcase
    endfunction

    // small window of 64 doublewords over 4 tags, so hits and misses mix
    task automatic build_random_rows(input int count);
        logic [31:0] r;
        size_t       sz;
        addr_t       a0;
        addr_t       a1;
        logic        v0;
        logic        v1;
        int          n;
        for (n = 0; n < count; n++) begin
            r = $random(seed);
            sz = {1'b0, r[1:0]};
            a0 = align_to_size(32'h0000_1000 | {23'h0, r[12:4]}, sz);
            a1 = align_to_size(32'h0000_1000 | {23'h0, r[21:13]}, sz);
            v0 = r[22];
            v1 = r[23];
            if (!v0 && !v1) begin
                v0 = 1'b1;
            end
            add_row($sformatf("rand_%0d", n), a0, v0, a1, v1, sz, 0);
        end
    endtask

    task automatic apply_row(input int idx);
        string name;
        int    edges;
        logic  seen;
        int    n;
        name = row_name[idx];
        @(posedge clk);
        #2;
        a_valid     = 1'b1;
        op0_address = row_addr0[idx];
        op0_valid   = row_valid0[idx];
        op1_address = row_addr1[idx];
        op1_valid   = row_valid1[idx];
        size        = row_size[idx];
        if (!row_valid0[idx] && !row_valid1[idx]) begin
            // nothing to load, interface has to stay idle
            for (n = 0; n < idle_window; n++) begin
                @(negedge clk);
                check_value({name, "_no_e_valid"}, 64'd0, 64'(e_valid));
            end
        end else begin
            edges = 0;
            seen = 1'b0;
            while (!seen && edges < timeout_cycles) begin
                @(posedge clk);
                edges++;
                @(negedge clk);
                seen = e_valid;
            end
            if (!seen) begin
                $display("e_valid never arrived for %s within %0d cycles", name, timeout_cycles);
                $display("TEST FAIL");
                $fatal(1, "timeout waiting for e_valid");
            end
            check_value({name, "_a_ready"}, 64'd1, 64'(a_ready));
            if (row_cycles[idx] != 0) begin
                check_value({name, "_cycles"}, 64'(row_cycles[idx]), 64'(edges));
            end
            if (row_valid0[idx]) begin
                exp_op0 = expected_load(row_addr0[idx], row_size[idx]);
            end
            if (row_valid1[idx]) begin
                exp_op1 = expected_load(row_addr1[idx], row_size[idx]);
            end
        end
        check_value({name, "_op0"}, exp_op0, op0_data);
        check_value({name, "_op1"}, exp_op1, op1_data);
        @(posedge clk);
        #2;
        a_valid   = 1'b0;
        op0_valid = 1'b0;
        op1_valid = 1'b0;
        // e_valid is a one cycle pulse
        @(negedge clk);
        check_value({name, "_single_pulse"}, 64'd0, 64'(e_valid));
    endtask

    initial begin
        int i;
        rst         = 1'b1;
        a_valid     = 1'b0;
        op0_valid   = 1'b0;
        op1_valid   = 1'b0;
        op0_address = '0;
        op1_address = '0;
        size        = '0;
        seed        = 97535;
        exp_op0     = '0;
        exp_op1     = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("reset_op0", 64'd0, op0_data);
        check_value("reset_op1", 64'd0, op1_data);
        check_value("reset_e_valid", 64'd0, 64'(e_valid));
        check_value("reset_a_ready", 64'd0, 64'(a_ready));

        add_row("op0_only_8b", 32'h0000_0100, 1'b1, 32'h0, 1'b0, SZ_8, 0);
        add_row("op1_only_8b", 32'h0, 1'b0, 32'h0000_0188, 1'b1, SZ_8, 0);
        add_row("both_8b", 32'h0000_0200, 1'b1, 32'h0000_0288, 1'b1, SZ_8, 0);
        add_row("size1_off5", 32'h0000_0305, 1'b1, 32'h0000_0383, 1'b1, SZ_1, 0);
        add_row("size2_off6", 32'h0000_0316, 1'b1, 32'h0, 1'b0, SZ_2, 0);
        add_row("size4_off4", 32'h0, 1'b0, 32'h0000_0324, 1'b1, SZ_4, 0);
        add_row("size_code7", 32'h0000_0340, 1'b1, 32'h0, 1'b0, 3'd7, 0);
        // request, wait, capture and done around the cache latency
        add_row("lat_miss", 32'h0000_2a08, 1'b1, 32'h0, 1'b0, SZ_8, 3 + MISS_LATENCY);
        add_row("lat_hit", 32'h0000_2a08, 1'b1, 32'h0, 1'b0, SZ_8, 3 + HIT_LATENCY);
        add_row("lat_hit_op1", 32'h0, 1'b0, 32'h0000_2a0c, 1'b1, SZ_4, 3 + HIT_LATENCY);
        add_row("no_operand", 32'h0000_0100, 1'b0, 32'h0000_0188, 1'b0, SZ_8, 0);
        add_row("both_same_line", 32'h0000_0500, 1'b1, 32'h0000_0504, 1'b1, SZ_4, 0);
        build_random_rows(24);

        for (i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
common/mem_stage_pkg.sv
dcache_interface/dcache_ctrl_store.sv
dcache_interface/dcache_microsequencer.sv
dcache_interface/dcache_interface.sv
dcache/dcache.sv
source/mem_stage_top.sv
verif/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the memory stage testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_mem_stage \
    -f sources.f -o tb_mem_stage > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_mem_stage 2>&1 | tee sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
